//--- source/rv_decode_pkg.sv
/*
 * Shared constants and control structs for the RV32I decode stage.
 * Opcode, funct3 and select encodings live here with the no-operation words.
 */
package rv_decode_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;
    localparam int REG_IDX_W  = 5;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;   // SRL and SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    localparam logic [1:0] ALU_UNIT_ADD   = 2'b00;
    localparam logic [1:0] ALU_UNIT_LOGIC = 2'b01;
    localparam logic [1:0] ALU_UNIT_SHIFT = 2'b10;
    localparam logic [1:0] ALU_UNIT_CMP   = 2'b11;

    localparam logic [3:0] ALU_OP_ADD = 4'b0000;
    localparam logic [3:0] ALU_OP_SUB = 4'b1000;
    localparam logic [3:0] ALU_OP_SRL = 4'b0001;
    localparam logic [3:0] ALU_OP_GE  = 4'b0010;
    localparam logic [3:0] ALU_OP_SLT = 4'b0011;
    localparam logic [3:0] ALU_OP_XOR = 4'b0100;
    localparam logic [3:0] ALU_OP_OR  = 4'b0110;
    localparam logic [3:0] ALU_OP_U   = 4'b0111;   // Unsigned and arithmetic variants

    localparam logic [1:0] PC_SEL_NONE = 2'b00;
    localparam logic [1:0] PC_SEL_PC   = 2'b01;
    localparam logic [1:0] PC_SEL_ZERO = 2'b10;

    localparam logic [1:0] WB_SRC_ALU = 2'b00;
    localparam logic [1:0] WB_SRC_MEM = 2'b01;
    localparam logic [1:0] WB_SRC_PC4 = 2'b10;
    localparam logic [1:0] WB_SRC_CSR = 2'b11;

    localparam logic [2:0] CSR_OP_NONE = 3'b000;
    localparam logic [2:0] CSR_OP_RW   = 3'b001;
    localparam logic [2:0] CSR_OP_RS   = 3'b010;
    localparam logic [2:0] CSR_OP_RC   = 3'b011;
    localparam logic [2:0] CSR_OP_RWI  = 3'b101;
    localparam logic [2:0] CSR_OP_RSI  = 3'b110;
    localparam logic [2:0] CSR_OP_RCI  = 3'b111;

    localparam logic [3:0] MASK_B = 4'b0001;
    localparam logic [3:0] MASK_H = 4'b0011;
    localparam logic [3:0] MASK_W = 4'b1111;

    typedef enum logic [3:0] {
        CLS_NONE,
        CLS_OP,
        CLS_OP_IMM,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_LUI,
        CLS_AUIPC,
        CLS_CSR
    } instr_class_e;

    typedef struct packed {
        logic       imm_sel;
        logic [1:0] pc_sel;
        logic       src1_pc;
        logic [1:0] unit_sel;
        logic [3:0] op;
    } alu_ctrl_t;

    typedef struct packed {
        logic [3:0] mask;
        logic       is_unsigned;
        logic       st_en;
    } mem_ctrl_t;

    typedef struct packed {
        logic       w_en;
        logic [1:0] src;
        logic       branch;
        logic       jump;
    } wb_ctrl_t;

    typedef struct packed {
        logic                  r_en;
        logic                  w_en;
        logic [2:0]            op;
        logic [CSR_ADDR_W-1:0] addr;
        logic                  imm_sel;
    } csr_ctrl_t;

    typedef struct packed {
        alu_ctrl_t alu;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
        csr_ctrl_t csr;
    } ctrl_word_t;

    localparam alu_ctrl_t ALU_CTRL_NOP = '{imm_sel: 1'b1, pc_sel: PC_SEL_NONE, src1_pc: 1'b0,
                                           unit_sel: ALU_UNIT_ADD, op: ALU_OP_ADD};
    localparam mem_ctrl_t MEM_CTRL_NOP = '{mask: 4'b0000, is_unsigned: 1'b0, st_en: 1'b0};
    localparam wb_ctrl_t  WB_CTRL_NOP  = '{w_en: 1'b0, src: WB_SRC_ALU, branch: 1'b0,
                                           jump: 1'b0};
    localparam csr_ctrl_t CSR_CTRL_NOP = '{r_en: 1'b0, w_en: 1'b0, op: CSR_OP_NONE,
                                           addr: '0, imm_sel: 1'b0};
    localparam ctrl_word_t CTRL_NOP    = '{alu: ALU_CTRL_NOP, mem: MEM_CTRL_NOP,
                                           wb: WB_CTRL_NOP, csr: CSR_CTRL_NOP};

endpackage

//--- source/instr_classify.sv
/*
 * Sorts an instruction word into one decode class from opcode and funct3.
 * Unknown opcodes and illegal funct3 values fall into CLS_NONE.
 */
`timescale 1ns/100ps

module instr_classify
(
    input  logic [rv_decode_pkg::XLEN-1:0] instr,
    output rv_decode_pkg::instr_class_e    cls
);
    import rv_decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb
    begin
        cls = CLS_NONE;
        case (opcode)
            OPC_OP:     cls = CLS_OP;
            OPC_OP_IMM: cls = CLS_OP_IMM;
            OPC_LOAD:
            begin
                if (funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU})
                    cls = CLS_LOAD;
            end
            OPC_STORE:
            begin
                if (funct3 inside {F3_B, F3_H, F3_W})
                    cls = CLS_STORE;
            end
            OPC_BRANCH:
            begin
                if (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU})
                    cls = CLS_BRANCH;
            end
            OPC_JAL:    cls = CLS_JAL;
            OPC_JALR:   cls = CLS_JALR;
            OPC_LUI:    cls = CLS_LUI;
            OPC_AUIPC:  cls = CLS_AUIPC;
            OPC_SYSTEM:
            begin
                if (funct3 inside {F3_CSRRW, F3_CSRRS, F3_CSRRC,
                                   F3_CSRRWI, F3_CSRRSI, F3_CSRRCI})
                    cls = CLS_CSR;   // ECALL, EBREAK and MRET stay NONE
            end
            default:    cls = CLS_NONE;
        endcase
    end

    always_comb
    begin
        if (!$isunknown(instr))
            a_cls_known: assert (!$isunknown(cls))
                else $error("decode class is unknown for a known instruction");
    end

endmodule

//--- source/alu_decode.sv
/*
 * ALU control for one instruction class: operand selects, result unit and op code.
 * Bit 30 picks SUB for register ops and the arithmetic shift for both ALU forms.
 */
`timescale 1ns/100ps

module alu_decode
(
    input  rv_decode_pkg::instr_class_e cls,
    input  logic [2:0]                  funct3,
    input  logic                        alt,
    output rv_decode_pkg::alu_ctrl_t    alu
);
    import rv_decode_pkg::*;

    always_comb
    begin
        alu = ALU_CTRL_NOP;
        case (cls)
            CLS_OP, CLS_OP_IMM:
            begin
                alu.imm_sel = (cls == CLS_OP_IMM);
                case (funct3)
                    F3_ADD:
                    begin
                        alu.unit_sel = ALU_UNIT_ADD;
                        alu.op       = (cls == CLS_OP && alt) ? ALU_OP_SUB : ALU_OP_ADD;
                    end
                    F3_SLL:
                    begin
                        alu.unit_sel = ALU_UNIT_SHIFT;
                        alu.op       = ALU_OP_SLT;   // Left shift shares this code
                    end
                    F3_SLT:
                    begin
                        alu.unit_sel = ALU_UNIT_CMP;
                        alu.op       = ALU_OP_SLT;
                    end
                    F3_SLTU:
                    begin
                        alu.unit_sel = ALU_UNIT_CMP;
                        alu.op       = ALU_OP_U;
                    end
                    F3_XOR:
                    begin
                        alu.unit_sel = ALU_UNIT_LOGIC;
                        alu.op       = ALU_OP_XOR;
                    end
                    F3_SR:
                    begin
                        alu.unit_sel = ALU_UNIT_SHIFT;
                        alu.op       = alt ? ALU_OP_U : ALU_OP_SRL;
                    end
                    F3_OR:
                    begin
                        alu.unit_sel = ALU_UNIT_LOGIC;
                        alu.op       = ALU_OP_OR;
                    end
                    F3_AND:
                    begin
                        alu.unit_sel = ALU_UNIT_LOGIC;
                        alu.op       = ALU_OP_U;
                    end
                    default: alu.op = ALU_OP_ADD;
                endcase
            end
            CLS_BRANCH:
            begin
                alu.src1_pc = 1'b1;
                alu.pc_sel  = PC_SEL_PC;   // Target is PC plus offset
                case (funct3)
                    F3_BEQ:  alu.op = ALU_OP_ADD;
                    F3_BNE:  alu.op = ALU_OP_SRL;
                    F3_BLT:  alu.op = ALU_OP_SLT;
                    F3_BGE:  alu.op = ALU_OP_GE;
                    F3_BLTU: alu.op = ALU_OP_U;
                    F3_BGEU: alu.op = ALU_OP_OR;
                    default: alu.op = ALU_OP_ADD;
                endcase
            end
            CLS_JAL, CLS_AUIPC: alu.pc_sel = PC_SEL_PC;
            CLS_LUI:            alu.pc_sel = PC_SEL_ZERO;   // Zero plus upper immediate
            default:            alu = ALU_CTRL_NOP;
        endcase
    end

endmodule

//--- source/mem_decode.sv
/*
 * Load/store control: byte mask from the access size, sign handling and store enable.
 */
`timescale 1ns/100ps

module mem_decode
(
    input  rv_decode_pkg::instr_class_e cls,
    input  logic [2:0]                  funct3,
    output rv_decode_pkg::mem_ctrl_t    mem
);
    import rv_decode_pkg::*;

    logic is_mem;

    assign is_mem = (cls == CLS_LOAD) || (cls == CLS_STORE);

    always_comb
    begin
        mem = MEM_CTRL_NOP;
        if (is_mem)
        begin
            case (funct3[1:0])
                2'b00:   mem.mask = MASK_B;
                2'b01:   mem.mask = MASK_H;
                default: mem.mask = MASK_W;
            endcase
            mem.is_unsigned = (cls == CLS_LOAD) && (funct3 == F3_BU || funct3 == F3_HU);
            mem.st_en       = (cls == CLS_STORE);
        end
    end

endmodule

//--- source/writeback_decode.sv
/*
 * Register writeback control plus the branch and jump flags for the PC unit.
 * CSR reads are written back unless a swap form targets x0.
 */
`timescale 1ns/100ps

module writeback_decode
(
    input  rv_decode_pkg::instr_class_e          cls,
    input  logic [2:0]                           funct3,
    input  logic [rv_decode_pkg::REG_IDX_W-1:0] rd,
    output rv_decode_pkg::wb_ctrl_t             wb
);
    import rv_decode_pkg::*;

    always_comb
    begin
        wb = WB_CTRL_NOP;
        case (cls)
            CLS_OP, CLS_OP_IMM, CLS_LUI, CLS_AUIPC:
                wb.w_en = 1'b1;
            CLS_LOAD:
            begin
                wb.w_en = 1'b1;
                wb.src  = WB_SRC_MEM;
            end
            CLS_JAL, CLS_JALR:
            begin
                wb.w_en = 1'b1;
                wb.src  = WB_SRC_PC4;   // Link address
                wb.jump = 1'b1;
            end
            CLS_BRANCH:
                wb.branch = 1'b1;
            CLS_CSR:
            begin
                wb.w_en = funct3[1] || (rd != '0);   // Set and clear forms always write
                wb.src  = WB_SRC_CSR;
            end
            default:
                wb = WB_CTRL_NOP;
        endcase
    end

endmodule

//--- source/csr_decode.sv
/*
 * CSR unit control for the six Zicsr forms.
 * The read enable follows the register write decision made in writeback_decode.
 */
`timescale 1ns/100ps

module csr_decode
(
    input  rv_decode_pkg::instr_class_e           cls,
    input  logic [2:0]                            funct3,
    input  logic [rv_decode_pkg::REG_IDX_W-1:0]  rs1,
    input  logic [rv_decode_pkg::CSR_ADDR_W-1:0] csr_field,
    input  logic                                  rd_write,
    output rv_decode_pkg::csr_ctrl_t             csr
);
    import rv_decode_pkg::*;

    always_comb
    begin
        csr = CSR_CTRL_NOP;
        if (cls == CLS_CSR)
        begin
            csr.op      = funct3;
            csr.addr    = csr_field;
            csr.imm_sel = funct3[2];   // uimm in the rs1 field
            csr.r_en    = rd_write;
            case (funct3)
                CSR_OP_RW, CSR_OP_RWI:
                    csr.w_en = 1'b1;
                CSR_OP_RS, CSR_OP_RC, CSR_OP_RSI, CSR_OP_RCI:
                    csr.w_en = (rs1 != '0);   // x0 or zero uimm leaves the CSR alone
                default:
                    csr.w_en = 1'b0;
            endcase
        end
    end

    always_comb
    begin
        a_csr_w_class: assert (!csr.w_en || cls == CLS_CSR)
            else $error("CSR write enabled outside a CSR instruction");
    end

endmodule

//--- source/decode_stage.sv
/*
 * Decode stage top: classifies the instruction, runs the field decoders and
 * registers the joined control word. Latency is one clock, one instruction per cycle.
 */
`timescale 1ns/100ps

module decode_stage
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic [rv_decode_pkg::XLEN-1:0] instr,
    output rv_decode_pkg::ctrl_word_t      ctrl
);
    import rv_decode_pkg::*;

    instr_class_e          cls;
    logic [2:0]            funct3;
    logic [REG_IDX_W-1:0]  rd;
    logic [REG_IDX_W-1:0]  rs1;
    logic [CSR_ADDR_W-1:0] csr_field;
    alu_ctrl_t             alu;
    mem_ctrl_t             mem;
    wb_ctrl_t              wb;
    csr_ctrl_t             csr;
    ctrl_word_t            ctrl_next;

    assign funct3    = instr[14:12];
    assign rd        = instr[11:7];
    assign rs1       = instr[19:15];
    assign csr_field = instr[XLEN-1 -: CSR_ADDR_W];

    instr_classify u_classify (.instr(instr), .cls(cls));

    alu_decode u_alu (.cls(cls), .funct3(funct3), .alt(instr[30]), .alu(alu));

    mem_decode u_mem (.cls(cls), .funct3(funct3), .mem(mem));

    writeback_decode u_wb (.cls(cls), .funct3(funct3), .rd(rd), .wb(wb));

    csr_decode u_csr
    (
        .cls       (cls),
        .funct3    (funct3),
        .rs1       (rs1),
        .csr_field (csr_field),
        .rd_write  (wb.w_en),
        .csr       (csr)
    );

    assign ctrl_next = '{alu: alu, mem: mem, wb: wb, csr: csr};

    always_ff @(posedge clk)
    begin
        if (rst)
            ctrl <= CTRL_NOP;
        else
            ctrl <= ctrl_next;   // Pipeline register toward execute
    end

    a_no_branch_jump: assert property (@(posedge clk) !(ctrl.wb.branch && ctrl.wb.jump))
        else $error("branch and jump set together");

    // CSR read data must land in the register file
    a_csr_read_wb: assert property (@(posedge clk) disable iff (rst)
        ctrl.csr.r_en |-> (ctrl.wb.w_en && ctrl.wb.src == WB_SRC_CSR))
        else $error("CSR read without a CSR writeback");

endmodule

//--- verification/decode_checker.sv
/*
 * Checker for the decode stage. Queues the predicted control words and
 * compares each with the DUT output on the falling edge one cycle later.
 */
`timescale 1ns/100ps

module decode_checker
(
    input  logic                      clk,
    input  rv_decode_pkg::ctrl_word_t ctrl,
    input  rv_decode_pkg::ctrl_word_t exp_word,
    input  logic [2:0]                exp_test,
    input  logic                      exp_valid,
    input  logic                      flush,
    output logic                      done,
    output int                        error_count
);
    import rv_decode_pkg::*;

    typedef struct packed {
        ctrl_word_t word;
        logic [2:0] test;
    } pending_t;

    pending_t   pending[$];
    pending_t   head;
    logic [2:0] cur_test;
    logic       have_test    = 1'b0;
    logic       finished     = 1'b0;
    int         errors       = 0;
    int         test_checks  = 0;
    int         test_errors  = 0;
    int         total_checks = 0;

    assign done        = finished;
    assign error_count = errors;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "reset";
            3'd1:    return "alu_writeback";
            3'd2:    return "load_store";
            3'd3:    return "branch_jump_upper";
            3'd4:    return "csr";
            3'd5:    return "no_operation";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_test();
        $display("TEST %s finished: %0d checks, %0d errors",
                 test_name(cur_test), test_checks, test_errors);
    endtask

    // Push on the rising edge, compare on the falling edge
    always @(posedge clk or negedge clk)
    begin
        if (clk)
        begin
            if (exp_valid)
            begin
                head.word = exp_word;
                head.test = exp_test;
                pending.push_back(head);
            end
        end
        else if (pending.size() > 0)
        begin
            head = pending.pop_front();
            if (have_test && head.test != cur_test)
            begin
                report_test();   // Previous test is complete
                test_checks = 0;
                test_errors = 0;
            end
            cur_test  = head.test;
            have_test = 1'b1;
            test_checks++;
            total_checks++;
            if (ctrl !== head.word)
            begin
                $display("MISMATCH %s expected %h actual %h",
                         test_name(head.test), head.word, ctrl);
                test_errors++;
                errors++;
            end
        end
        else if (flush && !finished)
        begin
            if (have_test)
                report_test();
            if (total_checks == 0)
            begin
                $display("No expected control words reached the checker");
                errors++;
            end
            $display("Checks %0d, errors %0d", total_checks, errors);
            finished = 1'b1;
        end
    end

endmodule

//--- verification/decode_stage_tb.sv
/*
 * Testbench top for the decode stage. Drives seeded random instructions,
 * predicts each control word from the decode rules and hands it to the checker.
 */
`timescale 1ns/100ps

module decode_stage_tb;
    import rv_decode_pkg::*;

    logic            clk;
    logic            rst;
    logic [XLEN-1:0] instr;
    ctrl_word_t      ctrl;
    ctrl_word_t      exp_word;
    logic [2:0]      exp_test;
    logic            exp_valid;
    logic            flush;
    logic            done;
    int              error_count;
    int unsigned     seed_init;

    decode_stage uut (.clk(clk), .rst(rst), .instr(instr), .ctrl(ctrl));

    decode_checker u_check
    (
        .clk         (clk),
        .ctrl        (ctrl),
        .exp_word    (exp_word),
        .exp_test    (exp_test),
        .exp_valid   (exp_valid),
        .flush       (flush),
        .done        (done),
        .error_count (error_count)
    );

    always #50 clk = ~clk;

    function automatic ctrl_word_t nop_word();
        ctrl_word_t w;
        w             = '0;
        w.alu.imm_sel = 1'b1;
        return w;
    endfunction

    // Expected control word straight from the decode rules
    function automatic ctrl_word_t model_decode(input logic [XLEN-1:0] ins);
        ctrl_word_t e;
        logic [1:0] unit_tab [8];
        logic [3:0] op_tab [8];
        logic [3:0] br_tab [8];
        logic [6:0] opc;
        logic [2:0] f3;
        logic       rw_form;
        unit_tab = '{ALU_UNIT_ADD, ALU_UNIT_SHIFT, ALU_UNIT_CMP, ALU_UNIT_CMP,
                     ALU_UNIT_LOGIC, ALU_UNIT_SHIFT, ALU_UNIT_LOGIC, ALU_UNIT_LOGIC};
        op_tab   = '{ALU_OP_ADD, ALU_OP_SLT, ALU_OP_SLT, ALU_OP_U,
                     ALU_OP_XOR, ALU_OP_SRL, ALU_OP_OR, ALU_OP_U};
        br_tab   = '{ALU_OP_ADD, ALU_OP_SRL, ALU_OP_ADD, ALU_OP_ADD,
                     ALU_OP_SLT, ALU_OP_GE, ALU_OP_U, ALU_OP_OR};
        opc      = ins[6:0];
        f3       = ins[14:12];
        rw_form  = (f3[1:0] == 2'b01);
        e        = nop_word();
        case (opc)
            OPC_OP, OPC_OP_IMM:
            begin
                e.alu.imm_sel  = (opc == OPC_OP_IMM);
                e.alu.unit_sel = unit_tab[f3];
                e.alu.op       = op_tab[f3];
                if (ins[30] && f3 == F3_SR)
                    e.alu.op = ALU_OP_U;   // SRA and SRAI
                if (ins[30] && f3 == F3_ADD && opc == OPC_OP)
                    e.alu.op = ALU_OP_SUB;
                e.wb.w_en = 1'b1;
            end
            OPC_LOAD, OPC_STORE:
            begin
                if ((opc == OPC_LOAD && f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) ||
                    (opc == OPC_STORE && f3 <= 3'd2))
                begin
                    if (f3[1:0] == 2'b00)
                        e.mem.mask = MASK_B;
                    else if (f3[1:0] == 2'b01)
                        e.mem.mask = MASK_H;
                    else
                        e.mem.mask = MASK_W;
                    e.mem.is_unsigned = (opc == OPC_LOAD) && f3[2];
                    e.mem.st_en       = (opc == OPC_STORE);
                    e.wb.w_en         = (opc == OPC_LOAD);
                    e.wb.src          = (opc == OPC_LOAD) ? WB_SRC_MEM : WB_SRC_ALU;
                end
            end
            OPC_BRANCH:
            begin
                if (f3[2:1] != 2'b01)
                begin
                    e.alu.src1_pc = 1'b1;
                    e.alu.pc_sel  = PC_SEL_PC;
                    e.alu.op      = br_tab[f3];
                    e.wb.branch   = 1'b1;
                end
            end
            OPC_JAL, OPC_JALR:
            begin
                e.alu.pc_sel = (opc == OPC_JAL) ? PC_SEL_PC : PC_SEL_NONE;
                e.wb.w_en    = 1'b1;
                e.wb.src     = WB_SRC_PC4;
                e.wb.jump    = 1'b1;
            end
            OPC_LUI, OPC_AUIPC:
            begin
                e.alu.pc_sel = (opc == OPC_LUI) ? PC_SEL_ZERO : PC_SEL_PC;
                e.wb.w_en    = 1'b1;
            end
            OPC_SYSTEM:
            begin
                if (f3[1:0] != 2'b00)
                begin
                    e.csr.op      = f3;
                    e.csr.addr    = ins[31:20];
                    e.csr.imm_sel = f3[2];
                    e.wb.src      = WB_SRC_CSR;
                    e.wb.w_en     = rw_form ? (ins[11:7] != 5'd0) : 1'b1;
                    e.csr.r_en    = e.wb.w_en;
                    e.csr.w_en    = rw_form || (ins[19:15] != 5'd0);
                end
            end
            default: e = nop_word();
        endcase
        return e;
    endfunction

    function automatic logic [XLEN-1:0] random_instr(input logic [6:0] opc);
        logic [XLEN-1:0] ins;
        ins      = $urandom;
        ins[6:0] = opc;
        if ($urandom_range(3, 0) == 0)
            ins[11:7] = 5'd0;    // rd = x0
        if ($urandom_range(3, 0) == 0)
            ins[19:15] = 5'd0;   // rs1 = x0
        return ins;
    endfunction

    function automatic logic is_kept_opcode(input logic [6:0] opc);
        return opc inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH,
                           OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC, OPC_SYSTEM};
    endfunction

    // One instruction per clock, driven just after the edge
    task automatic drive_one(input logic [XLEN-1:0] ins, input logic [2:0] test_id,
                             input logic rst_val);
        @(posedge clk);
        #1;
        rst       = rst_val;
        instr     = ins;
        exp_word  = rst_val ? nop_word() : model_decode(ins);
        exp_test  = test_id;
        exp_valid = 1'b1;
    endtask

    initial
    begin
        int              i;
        int              wait_cycles;
        logic [6:0]      opc;
        logic [XLEN-1:0] ins;
        logic [2:0]      csr_forms [6];
        logic [XLEN-1:0] sys_words [3];
        seed_init = $urandom(32'ha8f5dc1a);
        csr_forms = '{F3_CSRRW, F3_CSRRS, F3_CSRRC, F3_CSRRWI, F3_CSRRSI, F3_CSRRCI};
        sys_words = '{32'h00000073, 32'h00100073, 32'h30200073};   // ECALL, EBREAK, MRET
        clk       = 1'b0;
        rst       = 1'b1;
        instr     = '0;
        exp_word  = nop_word();
        exp_test  = 3'd0;
        exp_valid = 1'b0;
        flush     = 1'b0;

        // Live ALU ops under reset, so only the reset can give the no-op word
        for (i = 0; i < 4; i++)   // Fifth reset edge comes with the first drive
            drive_one(random_instr(OPC_OP), 3'd0, 1'b1);

        for (i = 0; i < 120; i++)
            drive_one(random_instr($urandom_range(1, 0) ? OPC_OP : OPC_OP_IMM), 3'd1, 1'b0);

        for (i = 0; i < 80; i++)
            drive_one(random_instr($urandom_range(1, 0) ? OPC_LOAD : OPC_STORE), 3'd2, 1'b0);

        for (i = 0; i < 100; i++)
        begin
            case ($urandom_range(5, 0))
                0, 1:    opc = OPC_BRANCH;
                2:       opc = OPC_JAL;
                3:       opc = OPC_JALR;
                4:       opc = OPC_LUI;
                default: opc = OPC_AUIPC;
            endcase
            drive_one(random_instr(opc), 3'd3, 1'b0);
        end

        // Every CSR form against rd and rs1 both zero and nonzero
        for (i = 0; i < 96; i++)
        begin
            ins         = random_instr(OPC_SYSTEM);
            ins[14:12]  = csr_forms[i % 6];
            ins[11:7]   = ((i / 6) % 2 == 0) ? 5'd0 : 5'($urandom_range(31, 1));
            ins[19:15]  = ((i / 12) % 2 == 0) ? 5'd0 : 5'($urandom_range(31, 1));
            drive_one(ins, 3'd4, 1'b0);
        end

        for (i = 0; i < 80; i++)
        begin
            case (i % 4)
                0:
                begin
                    opc = 7'($urandom);
                    if (is_kept_opcode(opc))
                        opc = 7'b0001111;
                    ins = random_instr(opc);
                end
                1: ins = random_instr(7'b0001111);   // FENCE and FENCE.I
                2: ins = sys_words[(i / 4) % 3];
                default:
                begin
                    case ((i / 4) % 4)
                        0:
                        begin
                            ins        = random_instr(OPC_LOAD);
                            ins[14:12] = $urandom_range(1, 0) ? 3'b011 : 3'b111;
                        end
                        1:
                        begin
                            ins        = random_instr(OPC_STORE);
                            ins[14:12] = {1'b1, 2'($urandom)};
                        end
                        2:
                        begin
                            ins        = random_instr(OPC_BRANCH);
                            ins[14:12] = {2'b01, 1'($urandom)};
                        end
                        default:
                        begin
                            ins        = random_instr(OPC_SYSTEM);
                            ins[14:12] = {1'($urandom), 2'b00};
                        end
                    endcase
                end
            endcase
            drive_one(ins, 3'd5, 1'b0);
        end

        @(posedge clk);
        #1;
        exp_valid   = 1'b0;
        flush       = 1'b1;
        wait_cycles = 0;
        while (!done && wait_cycles < 20)
        begin
            @(posedge clk);
            wait_cycles++;
        end

        if (done && error_count == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            if (!done)
                $display("Checker did not finish within 20 cycles after the last instruction");
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- decode_stage.f
source/rv_decode_pkg.sv
source/instr_classify.sv
source/alu_decode.sv
source/mem_decode.sv
source/writeback_decode.sv
source/csr_decode.sv
source/decode_stage.sv
verification/decode_checker.sv
verification/decode_stage_tb.sv

//--- Makefile
# Verilator simulation of the RV32I decode stage

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= decode_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Finished with no errors" $(LOG) || \
		(echo "Simulation did not complete, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
